/* verilog/pss_pkg.sv */
package pss_pkg;

    // bus geometry
    localparam int AXI_ADDR_W = 11;
    localparam int REG_ADDR_W = AXI_ADDR_W - 2;
    localparam int DATA_W     = 32;
    localparam int CORR_W     = 32;
    localparam int COUNT_W    = 32;
    localparam int SHIFT_W    = 8;
    localparam int NID2_W     = 2;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [CORR_W-1:0]     corr_t;
    typedef logic [COUNT_W-1:0]    count_t;
    typedef logic [SHIFT_W-1:0]    shift_t;
    typedef logic [NID2_W-1:0]     nid2_t;

    // register map, word addresses
    localparam reg_addr_t REG_VERSION     = 9'h000;
    localparam reg_addr_t REG_ID          = 9'h001;
    localparam reg_addr_t REG_MAGIC       = 9'h003;
    localparam reg_addr_t REG_STATUS      = 9'h005;
    localparam reg_addr_t REG_PEAK_CNT0   = 9'h008;
    localparam reg_addr_t REG_PEAK_CNT1   = 9'h009;
    localparam reg_addr_t REG_PEAK_CNT2   = 9'h00A;
    localparam reg_addr_t REG_NOISE_LIMIT = 9'h00B;
    localparam reg_addr_t REG_DET_SHIFT   = 9'h00C;

    // status word layout, last index sits in the low bits
    localparam int STATUS_DET_BIT = 8;

    localparam data_t  PCORE_VERSION    = 32'h0004_0069;
    // ascii "PSSD"
    localparam data_t  PSS_MAGIC        = 32'h5053_5344;
    localparam corr_t  INIT_NOISE_LIMIT = corr_t'(2 ** (CORR_W / 2));
    localparam shift_t INIT_DET_SHIFT   = 8'd4;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

/* verilog/axi_lite_slave.sv */
`timescale 1ns/1ps

module axi_lite_slave (
    input  logic                clk_i,
    input  logic                reset_ni,

    input  pss_pkg::axi_addr_t  s_axi_awaddr_i,
    input  logic                s_axi_awvalid_i,
    output logic                s_axi_awready_o,
    input  pss_pkg::data_t      s_axi_wdata_i,
    // byte strobes are not supported, every write is a full word
    input  logic [3:0]          s_axi_wstrb_i,
    input  logic                s_axi_wvalid_i,
    output logic                s_axi_wready_o,
    output logic [1:0]          s_axi_bresp_o,
    output logic                s_axi_bvalid_o,
    input  logic                s_axi_bready_i,
    input  pss_pkg::axi_addr_t  s_axi_araddr_i,
    input  logic                s_axi_arvalid_i,
    output logic                s_axi_arready_o,
    output pss_pkg::data_t      s_axi_rdata_o,
    output logic [1:0]          s_axi_rresp_o,
    output logic                s_axi_rvalid_o,
    input  logic                s_axi_rready_i,

    output logic                wreq_o,
    output pss_pkg::reg_addr_t  waddr_o,
    output pss_pkg::data_t      wdata_o,
    input  logic                wack_i,
    output logic                rreq_o,
    output pss_pkg::reg_addr_t  raddr_o,
    input  pss_pkg::data_t      rdata_i,
    input  logic                rack_i
);

    typedef enum logic [2:0] {
        IDLE,
        WREQ,
        WWAIT,
        WRESP,
        RREQ,
        RWAIT,
        RRESP
    } state_t;

    state_t             state_q;
    logic               arready_q;
    logic               awready_q;
    logic               ar_hs;
    logic               aw_hs;
    pss_pkg::reg_addr_t addr_q;
    pss_pkg::data_t     wdata_q;
    pss_pkg::data_t     rdata_q;

    // awready and wready share one flag, address and data are taken together
    assign ar_hs = arready_q && s_axi_arvalid_i;
    assign aw_hs = awready_q && s_axi_awvalid_i && s_axi_wvalid_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q   <= IDLE;
            arready_q <= 1'b0;
            awready_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ar_hs) begin
                        arready_q <= 1'b0;
                        state_q   <= RREQ;
                    end else if (aw_hs) begin
                        awready_q <= 1'b0;
                        state_q   <= WREQ;
                    end else if (!arready_q && !awready_q) begin
                        // reads win when both channels are pending
                        if (s_axi_arvalid_i) begin
                            arready_q <= 1'b1;
                        end else if (s_axi_awvalid_i && s_axi_wvalid_i) begin
                            awready_q <= 1'b1;
                        end
                    end
                end
                WREQ:    state_q <= WWAIT;
                WWAIT:   if (wack_i) state_q <= WRESP;
                WRESP:   if (s_axi_bready_i) state_q <= IDLE;
                RREQ:    state_q <= RWAIT;
                RWAIT:   if (rack_i) state_q <= RRESP;
                RRESP:   if (s_axi_rready_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // byte address to word address
    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            addr_q <= s_axi_araddr_i[pss_pkg::AXI_ADDR_W-1:2];
        end else if (aw_hs) begin
            addr_q  <= s_axi_awaddr_i[pss_pkg::AXI_ADDR_W-1:2];
            wdata_q <= s_axi_wdata_i;
        end
        if (state_q == RWAIT && rack_i) begin
            rdata_q <= rdata_i;
        end
    end

    assign s_axi_arready_o = arready_q;
    assign s_axi_awready_o = awready_q;
    assign s_axi_wready_o  = awready_q;
    assign s_axi_bvalid_o  = (state_q == WRESP);
    assign s_axi_bresp_o   = pss_pkg::AXI_RESP_OKAY;
    assign s_axi_rvalid_o  = (state_q == RRESP);
    assign s_axi_rdata_o   = rdata_q;
    assign s_axi_rresp_o   = pss_pkg::AXI_RESP_OKAY;

    assign wreq_o  = (state_q == WREQ);
    assign waddr_o = addr_q;
    assign wdata_o = wdata_q;
    assign rreq_o  = (state_q == RREQ);
    assign raddr_o = addr_q;

endmodule

/* verilog/pss_detector_regmap.sv */
`timescale 1ns/1ps

module pss_detector_regmap #(
    parameter pss_pkg::data_t ID = '0
) (
    input  logic                clk_i,
    input  logic                reset_ni,

    input  pss_pkg::axi_addr_t  s_axi_awaddr_i,
    input  logic                s_axi_awvalid_i,
    output logic                s_axi_awready_o,
    input  pss_pkg::data_t      s_axi_wdata_i,
    input  logic [3:0]          s_axi_wstrb_i,
    input  logic                s_axi_wvalid_i,
    output logic                s_axi_wready_o,
    output logic [1:0]          s_axi_bresp_o,
    output logic                s_axi_bvalid_o,
    input  logic                s_axi_bready_i,
    input  pss_pkg::axi_addr_t  s_axi_araddr_i,
    input  logic                s_axi_arvalid_i,
    output logic                s_axi_arready_o,
    output pss_pkg::data_t      s_axi_rdata_o,
    output logic [1:0]          s_axi_rresp_o,
    output logic                s_axi_rvalid_o,
    input  logic                s_axi_rready_i,

    input  pss_pkg::count_t     cnt0_i,
    input  pss_pkg::count_t     cnt1_i,
    input  pss_pkg::count_t     cnt2_i,
    input  pss_pkg::nid2_t      last_nid2_i,
    input  logic                detected_i,
    output pss_pkg::corr_t      noise_limit_o,
    output pss_pkg::shift_t     det_shift_o
);

    logic               wreq;
    logic               rreq;
    logic               wack_q;
    logic               rack_q;
    pss_pkg::reg_addr_t waddr;
    pss_pkg::reg_addr_t raddr;
    pss_pkg::data_t     wdata;
    pss_pkg::data_t     rdata_q;
    pss_pkg::data_t     status_word;

    always_comb begin
        status_word = '0;
        status_word[pss_pkg::NID2_W-1:0] = last_nid2_i;
        status_word[pss_pkg::STATUS_DET_BIT] = detected_i;
    end

    // every request is answered on the following cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wack_q <= 1'b0;
            rack_q <= 1'b0;
        end else begin
            wack_q <= wreq;
            rack_q <= rreq;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            noise_limit_o <= pss_pkg::INIT_NOISE_LIMIT;
            det_shift_o   <= pss_pkg::INIT_DET_SHIFT;
        end else if (wreq) begin
            // read-only addresses take the ack and drop the data
            if (waddr == pss_pkg::REG_NOISE_LIMIT) begin
                noise_limit_o <= wdata[pss_pkg::CORR_W-1:0];
            end
            if (waddr == pss_pkg::REG_DET_SHIFT) begin
                det_shift_o <= wdata[pss_pkg::SHIFT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rreq) begin
            case (raddr)
                pss_pkg::REG_VERSION:     rdata_q <= pss_pkg::PCORE_VERSION;
                pss_pkg::REG_ID:          rdata_q <= ID;
                pss_pkg::REG_MAGIC:       rdata_q <= pss_pkg::PSS_MAGIC;
                pss_pkg::REG_STATUS:      rdata_q <= status_word;
                pss_pkg::REG_PEAK_CNT0:   rdata_q <= pss_pkg::data_t'(cnt0_i);
                pss_pkg::REG_PEAK_CNT1:   rdata_q <= pss_pkg::data_t'(cnt1_i);
                pss_pkg::REG_PEAK_CNT2:   rdata_q <= pss_pkg::data_t'(cnt2_i);
                pss_pkg::REG_NOISE_LIMIT: rdata_q <= pss_pkg::data_t'(noise_limit_o);
                pss_pkg::REG_DET_SHIFT:   rdata_q <= pss_pkg::data_t'(det_shift_o);
                default:                  rdata_q <= '0;
            endcase
        end
    end

    axi_lite_slave i_axi_lite_slave (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .wreq_o          (wreq),
        .waddr_o         (waddr),
        .wdata_o         (wdata),
        .wack_i          (wack_q),
        .rreq_o          (rreq),
        .raddr_o         (raddr),
        .rdata_i         (rdata_q),
        .rack_i          (rack_q)
    );

endmodule

/* verilog/pss_peak_detector.sv */
`timescale 1ns/1ps

module pss_peak_detector (
    input  logic             clk_i,
    input  logic             reset_ni,

    input  logic             corr_valid_i,
    input  pss_pkg::corr_t   corr_mag0_i,
    input  pss_pkg::corr_t   corr_mag1_i,
    input  pss_pkg::corr_t   corr_mag2_i,
    input  pss_pkg::corr_t   energy_i,

    input  pss_pkg::corr_t   noise_limit_i,
    input  pss_pkg::shift_t  det_shift_i,

    output logic             peak_valid_o,
    output pss_pkg::nid2_t   peak_nid2_o,
    output pss_pkg::count_t  cnt0_o,
    output pss_pkg::count_t  cnt1_o,
    output pss_pkg::count_t  cnt2_o,
    output pss_pkg::nid2_t   last_nid2_o,
    output logic             detected_o
);

    pss_pkg::corr_t  mag [3];
    pss_pkg::corr_t  energy_thr;
    logic [2:0]      pass;
    pss_pkg::nid2_t  first_pass;
    pss_pkg::count_t cnt_q [3];
    logic            peak_valid_q;
    pss_pkg::nid2_t  last_nid2_q;
    logic            detected_q;

    assign mag[0] = corr_mag0_i;
    assign mag[1] = corr_mag1_i;
    assign mag[2] = corr_mag2_i;

    // scaled energy, bits shifted past CORR_W are lost
    assign energy_thr = energy_i << det_shift_i;

    always_comb begin
        for (int k = 0; k < 3; k++) begin
            pass[k] = (mag[k] > noise_limit_i) && (mag[k] > energy_thr);
        end
    end

    // lowest passing candidate wins
    always_comb begin
        if (pass[0]) begin
            first_pass = 2'd0;
        end else if (pass[1]) begin
            first_pass = 2'd1;
        end else begin
            first_pass = 2'd2;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            peak_valid_q <= 1'b0;
            last_nid2_q  <= '0;
            detected_q   <= 1'b0;
            for (int k = 0; k < 3; k++) begin
                cnt_q[k] <= '0;
            end
        end else begin
            peak_valid_q <= corr_valid_i && (|pass);
            if (corr_valid_i && (|pass)) begin
                last_nid2_q <= first_pass;
                detected_q  <= 1'b1;
            end
            // counters wrap on overflow
            for (int k = 0; k < 3; k++) begin
                if (corr_valid_i && pass[k]) begin
                    cnt_q[k] <= cnt_q[k] + 1'b1;
                end
            end
        end
    end

    assign peak_valid_o = peak_valid_q;
    assign peak_nid2_o  = last_nid2_q;
    assign last_nid2_o  = last_nid2_q;
    assign detected_o   = detected_q;
    assign cnt0_o       = cnt_q[0];
    assign cnt1_o       = cnt_q[1];
    assign cnt2_o       = cnt_q[2];

endmodule

/* verilog/pss_detector_top.sv */
`timescale 1ns/1ps

module pss_detector_top #(
    parameter pss_pkg::data_t ID = '0
) (
    input  logic                clk_i,
    input  logic                reset_ni,

    input  pss_pkg::axi_addr_t  s_axi_awaddr_i,
    input  logic                s_axi_awvalid_i,
    output logic                s_axi_awready_o,
    input  pss_pkg::data_t      s_axi_wdata_i,
    input  logic [3:0]          s_axi_wstrb_i,
    input  logic                s_axi_wvalid_i,
    output logic                s_axi_wready_o,
    output logic [1:0]          s_axi_bresp_o,
    output logic                s_axi_bvalid_o,
    input  logic                s_axi_bready_i,
    input  pss_pkg::axi_addr_t  s_axi_araddr_i,
    input  logic                s_axi_arvalid_i,
    output logic                s_axi_arready_o,
    output pss_pkg::data_t      s_axi_rdata_o,
    output logic [1:0]          s_axi_rresp_o,
    output logic                s_axi_rvalid_o,
    input  logic                s_axi_rready_i,

    // one sample per cycle from the correlator
    input  logic                corr_valid_i,
    input  pss_pkg::corr_t      corr_mag0_i,
    input  pss_pkg::corr_t      corr_mag1_i,
    input  pss_pkg::corr_t      corr_mag2_i,
    input  pss_pkg::corr_t      energy_i,

    output logic                peak_valid_o,
    output pss_pkg::nid2_t      peak_nid2_o
);

    pss_pkg::corr_t  noise_limit;
    pss_pkg::shift_t det_shift;
    pss_pkg::count_t cnt0;
    pss_pkg::count_t cnt1;
    pss_pkg::count_t cnt2;
    pss_pkg::nid2_t  last_nid2;
    logic            detected;

    pss_peak_detector i_pss_peak_detector (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .corr_valid_i  (corr_valid_i),
        .corr_mag0_i   (corr_mag0_i),
        .corr_mag1_i   (corr_mag1_i),
        .corr_mag2_i   (corr_mag2_i),
        .energy_i      (energy_i),
        .noise_limit_i (noise_limit),
        .det_shift_i   (det_shift),
        .peak_valid_o  (peak_valid_o),
        .peak_nid2_o   (peak_nid2_o),
        .cnt0_o        (cnt0),
        .cnt1_o        (cnt1),
        .cnt2_o        (cnt2),
        .last_nid2_o   (last_nid2),
        .detected_o    (detected)
    );

    pss_detector_regmap #(
        .ID (ID)
    ) i_pss_detector_regmap (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .cnt0_i          (cnt0),
        .cnt1_i          (cnt1),
        .cnt2_i          (cnt2),
        .last_nid2_i     (last_nid2),
        .detected_i      (detected),
        .noise_limit_o   (noise_limit),
        .det_shift_o     (det_shift)
    );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

/* verif/tb_pss_checker.sv */
`timescale 1ns/1ps

module tb_pss_checker #(
    parameter pss_pkg::data_t ID = '0
) (
    input  logic               clk_i,
    input  logic               reset_ni,

    input  pss_pkg::axi_addr_t awaddr_i,
    input  logic               awvalid_i,
    input  logic               awready_i,
    input  pss_pkg::data_t     wdata_i,
    input  logic               wvalid_i,
    input  logic               wready_i,
    input  logic [1:0]         bresp_i,
    input  logic               bvalid_i,
    input  logic               bready_i,
    input  pss_pkg::axi_addr_t araddr_i,
    input  logic               arvalid_i,
    input  logic               arready_i,
    input  pss_pkg::data_t     rdata_i,
    input  logic [1:0]         rresp_i,
    input  logic               rvalid_i,
    input  logic               rready_i,

    input  logic               corr_valid_i,
    input  pss_pkg::corr_t     mag0_i,
    input  pss_pkg::corr_t     mag1_i,
    input  pss_pkg::corr_t     mag2_i,
    input  pss_pkg::corr_t     energy_i,
    input  logic               peak_valid_i,
    input  pss_pkg::nid2_t     peak_nid2_i,

    output int                 err_count_o,
    output int                 check_count_o
);

    // model of the detector state and the two writable registers
    pss_pkg::corr_t     noise_m;
    pss_pkg::shift_t    shift_m;
    pss_pkg::count_t    cnt_m [3];
    pss_pkg::nid2_t     last_m;
    logic               det_m;

    logic               exp_peak_q;
    pss_pkg::nid2_t     exp_nid2_q;
    logic               wr_pend;
    pss_pkg::reg_addr_t wr_addr;
    pss_pkg::data_t     wr_data;
    logic               rd_pend;
    pss_pkg::reg_addr_t rd_addr;
    pss_pkg::data_t     exp_rdata;
    logic               busy;
    logic               r_hold;
    logic               b_hold;
    pss_pkg::data_t     held_rdata;
    int                 errors = 0;
    int                 checks = 0;

    assign err_count_o   = errors;
    assign check_count_o = checks;

    task automatic report(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    function automatic pss_pkg::data_t model_read(input pss_pkg::reg_addr_t a);
        case (a)
            pss_pkg::REG_VERSION:     return 32'h0004_0069;
            pss_pkg::REG_ID:          return ID;
            pss_pkg::REG_MAGIC:       return 32'h5053_5344;
            pss_pkg::REG_STATUS:      return {23'd0, det_m, 6'd0, last_m};
            pss_pkg::REG_PEAK_CNT0:   return cnt_m[0];
            pss_pkg::REG_PEAK_CNT1:   return cnt_m[1];
            pss_pkg::REG_PEAK_CNT2:   return cnt_m[2];
            pss_pkg::REG_NOISE_LIMIT: return noise_m;
            pss_pkg::REG_DET_SHIFT:   return {24'd0, shift_m};
            default:                  return 32'd0;
        endcase
    endfunction

    always @(posedge clk_i) begin
        logic [2:0]     pass;
        pss_pkg::corr_t thr;
        logic           aw_hs;
        logic           ar_hs;
        if (!reset_ni) begin
            noise_m    = 32'd65536;
            shift_m    = 8'd4;
            cnt_m[0]   = '0;
            cnt_m[1]   = '0;
            cnt_m[2]   = '0;
            last_m     = '0;
            det_m      = 1'b0;
            exp_peak_q = 1'b0;
            exp_nid2_q = '0;
            wr_pend    = 1'b0;
            rd_pend    = 1'b0;
            busy       = 1'b0;
            r_hold     = 1'b0;
            b_hold     = 1'b0;
        end else begin
            aw_hs = awvalid_i && awready_i && wvalid_i && wready_i;
            ar_hs = arvalid_i && arready_i;

            // detection of the sample from the previous cycle
            checks++;
            if (peak_valid_i !== exp_peak_q || (exp_peak_q && peak_nid2_i !== exp_nid2_q)) begin
                report($sformatf("peak valid %0b nid2 %0d, expected valid %0b nid2 %0d",
                                 peak_valid_i, peak_nid2_i, exp_peak_q, exp_nid2_q));
            end

            // read data is sampled in the cycle after the address handshake
            if (rd_pend) begin
                exp_rdata = model_read(rd_addr);
                rd_pend   = 1'b0;
            end

            thr = energy_i << shift_m;
            pass[0] = corr_valid_i && (mag0_i > noise_m) && (mag0_i > thr);
            pass[1] = corr_valid_i && (mag1_i > noise_m) && (mag1_i > thr);
            pass[2] = corr_valid_i && (mag2_i > noise_m) && (mag2_i > thr);
            exp_peak_q = |pass;
            if (|pass) begin
                exp_nid2_q = pass[0] ? 2'd0 : (pass[1] ? 2'd1 : 2'd2);
                last_m     = exp_nid2_q;
                det_m      = 1'b1;
            end
            for (int k = 0; k < 3; k++) begin
                if (pass[k]) begin
                    cnt_m[k] = cnt_m[k] + 32'd1;
                end
            end

            // thresholds change one cycle after the write handshake
            if (wr_pend) begin
                if (wr_addr == pss_pkg::REG_NOISE_LIMIT) noise_m = wr_data;
                if (wr_addr == pss_pkg::REG_DET_SHIFT) shift_m = wr_data[7:0];
                wr_pend = 1'b0;
            end

            if (r_hold && (!rvalid_i || rdata_i !== held_rdata)) begin
                report("rvalid or rdata changed while rready was low");
            end
            if (b_hold && !bvalid_i) begin
                report("bvalid dropped while bready was low");
            end
            r_hold     = rvalid_i && !rready_i;
            held_rdata = rdata_i;
            b_hold     = bvalid_i && !bready_i;

            if (awready_i !== wready_i) begin
                report($sformatf("awready %0b and wready %0b differ", awready_i, wready_i));
            end
            if ((arready_i || awready_i) && busy) begin
                report("ready raised while a transaction was in flight");
            end
            if (ar_hs && aw_hs) begin
                report("read and write addresses accepted in the same cycle");
            end
            if (ar_hs) begin
                busy    = 1'b1;
                rd_pend = 1'b1;
                rd_addr = araddr_i[pss_pkg::AXI_ADDR_W-1:2];
            end else if (aw_hs) begin
                busy    = 1'b1;
                wr_pend = 1'b1;
                wr_addr = awaddr_i[pss_pkg::AXI_ADDR_W-1:2];
                wr_data = wdata_i;
            end

            if (rvalid_i && rready_i) begin
                checks++;
                if (rdata_i !== exp_rdata || rresp_i !== 2'b00) begin
                    report($sformatf("read word 0x%03h gave 0x%08h resp %0d, expected 0x%08h",
                                     rd_addr, rdata_i, rresp_i, exp_rdata));
                end
                busy = 1'b0;
            end
            if (bvalid_i && bready_i) begin
                checks++;
                if (bresp_i !== 2'b00) begin
                    report($sformatf("write response %0d, expected OKAY", bresp_i));
                end
                busy = 1'b0;
            end
        end
    end

endmodule

/* verif/tb_pss_top.sv */
`timescale 1ns/1ps

module tb_pss_top;

    localparam pss_pkg::data_t DUT_ID     = 32'h0000_00A5;
    localparam int             WAIT_LIMIT = 50;

    logic               clk;
    logic               reset_n;
    pss_pkg::axi_addr_t awaddr;
    logic               awvalid;
    logic               awready;
    pss_pkg::data_t     wdata;
    logic [3:0]         wstrb;
    logic               wvalid;
    logic               wready;
    logic [1:0]         bresp;
    logic               bvalid;
    logic               bready;
    pss_pkg::axi_addr_t araddr;
    logic               arvalid;
    logic               arready;
    pss_pkg::data_t     rdata;
    logic [1:0]         rresp;
    logic               rvalid;
    logic               rready;
    logic               corr_valid;
    pss_pkg::corr_t     mag0;
    pss_pkg::corr_t     mag1;
    pss_pkg::corr_t     mag2;
    pss_pkg::corr_t     energy;
    logic               peak_valid;
    pss_pkg::nid2_t     peak_nid2;

    logic [31:0]        lfsr_q;
    int                 err_count;
    int                 check_count;
    int                 err_before;
    int                 tests_run;
    int                 tests_failed;

    tb_clk_gen #(.PERIOD_NS(20.0)) i_tb_clk_gen (.clk_o(clk));

    pss_detector_top #(.ID(DUT_ID)) i_pss_detector_top (
        .clk_i           (clk),
        .reset_ni        (reset_n),
        .s_axi_awaddr_i  (awaddr),
        .s_axi_awvalid_i (awvalid),
        .s_axi_awready_o (awready),
        .s_axi_wdata_i   (wdata),
        .s_axi_wstrb_i   (wstrb),
        .s_axi_wvalid_i  (wvalid),
        .s_axi_wready_o  (wready),
        .s_axi_bresp_o   (bresp),
        .s_axi_bvalid_o  (bvalid),
        .s_axi_bready_i  (bready),
        .s_axi_araddr_i  (araddr),
        .s_axi_arvalid_i (arvalid),
        .s_axi_arready_o (arready),
        .s_axi_rdata_o   (rdata),
        .s_axi_rresp_o   (rresp),
        .s_axi_rvalid_o  (rvalid),
        .s_axi_rready_i  (rready),
        .corr_valid_i    (corr_valid),
        .corr_mag0_i     (mag0),
        .corr_mag1_i     (mag1),
        .corr_mag2_i     (mag2),
        .energy_i        (energy),
        .peak_valid_o    (peak_valid),
        .peak_nid2_o     (peak_nid2)
    );

    tb_pss_checker #(.ID(DUT_ID)) i_tb_pss_checker (
        .clk_i         (clk),
        .reset_ni      (reset_n),
        .awaddr_i      (awaddr),
        .awvalid_i     (awvalid),
        .awready_i     (awready),
        .wdata_i       (wdata),
        .wvalid_i      (wvalid),
        .wready_i      (wready),
        .bresp_i       (bresp),
        .bvalid_i      (bvalid),
        .bready_i      (bready),
        .araddr_i      (araddr),
        .arvalid_i     (arvalid),
        .arready_i     (arready),
        .rdata_i       (rdata),
        .rresp_i       (rresp),
        .rvalid_i      (rvalid),
        .rready_i      (rready),
        .corr_valid_i  (corr_valid),
        .mag0_i        (mag0),
        .mag1_i        (mag1),
        .mag2_i        (mag2),
        .energy_i      (energy),
        .peak_valid_i  (peak_valid),
        .peak_nid2_i   (peak_nid2),
        .err_count_o   (err_count),
        .check_count_o (check_count)
    );

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic give_up(input string what);
        $display("timeout: no %s within %0d cycles at %0t ns", what, WAIT_LIMIT, $time);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic axi_read(input pss_pkg::reg_addr_t word, input int stall_bits);
        int n;
        @(negedge clk);
        araddr  = {word, 2'b00};
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) give_up("arready");
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) give_up("rvalid");
        end
        // back-pressure before taking the data
        repeat (int'(rand_bits(stall_bits))) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic axi_write(input pss_pkg::reg_addr_t word, input pss_pkg::data_t data,
                             input int stall_bits);
        int n;
        @(negedge clk);
        awaddr  = {word, 2'b00};
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) give_up("awready and wready");
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) give_up("bvalid");
        end
        repeat (int'(rand_bits(stall_bits))) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    // random widths put values on both sides of each threshold
    task automatic drive_samples(input int count);
        for (int k = 0; k < count; k++) begin
            @(negedge clk);
            corr_valid = (rand_bits(2) != 32'd0);
            mag0       = rand_bits(int'(rand_bits(5)) + 1);
            mag1       = rand_bits(int'(rand_bits(5)) + 1);
            mag2       = rand_bits(int'(rand_bits(5)) + 1);
            energy     = rand_bits(int'(rand_bits(5)) + 1);
        end
        @(negedge clk);
        corr_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        repeat (2) @(negedge clk);
        tests_run++;
        if (err_count != err_before) begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, err_count - err_before);
        end else begin
            $display("test %-16s ok", name);
        end
        err_before = err_count;
    endtask

    initial begin
        lfsr_q       = 32'h16115e68;
        err_before   = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_n      = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = 4'hF;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        corr_valid   = 1'b0;
        mag0         = '0;
        mag1         = '0;
        mag2         = '0;
        energy       = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        axi_read(pss_pkg::REG_VERSION, 0);
        axi_read(pss_pkg::REG_ID, 0);
        axi_read(pss_pkg::REG_MAGIC, 0);
        axi_read(pss_pkg::REG_NOISE_LIMIT, 1);
        axi_read(pss_pkg::REG_DET_SHIFT, 1);
        axi_read(9'h002, 1);
        axi_read(9'h1FF, 1);
        end_test("reset_values");

        axi_write(pss_pkg::REG_NOISE_LIMIT, 32'h0003_2A10, 1);
        axi_read(pss_pkg::REG_NOISE_LIMIT, 1);
        axi_write(pss_pkg::REG_DET_SHIFT, 32'h0000_01A3, 1);
        axi_read(pss_pkg::REG_DET_SHIFT, 1);
        axi_write(pss_pkg::REG_VERSION, 32'hFFFF_FFFF, 1);
        axi_read(pss_pkg::REG_VERSION, 0);
        axi_write(pss_pkg::REG_MAGIC, 32'h1234_5678, 1);
        axi_read(pss_pkg::REG_MAGIC, 0);
        end_test("register_rw");

        for (int i = 0; i < 4; i++) begin
            axi_write(pss_pkg::REG_NOISE_LIMIT, rand_bits(20), 1);
            axi_write(pss_pkg::REG_DET_SHIFT, rand_bits(3), 1);
            drive_samples(150);
        end
        end_test("peak_thresholds");

        drive_samples(300);
        axi_read(pss_pkg::REG_PEAK_CNT0, 2);
        axi_read(pss_pkg::REG_PEAK_CNT1, 2);
        axi_read(pss_pkg::REG_PEAK_CNT2, 2);
        axi_read(pss_pkg::REG_STATUS, 2);
        end_test("counters_status");

        // read and write channels compete, with long response stalls
        for (int i = 0; i < 8; i++) begin
            fork
                axi_write(pss_pkg::REG_NOISE_LIMIT, {12'd0, i[3:0], 16'h8000}, 3);
                axi_read(pss_pkg::REG_NOISE_LIMIT, 3);
            join
            axi_read(pss_pkg::REG_STATUS, 3);
        end
        end_test("back_pressure");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
verilog/pss_pkg.sv
verilog/axi_lite_slave.sv
verilog/pss_detector_regmap.sv
verilog/pss_peak_detector.sv
verilog/pss_detector_top.sv
verif/tb_clk_gen.sv
verif/tb_pss_checker.sv
verif/tb_pss_top.sv

/* run.sh */
#!/bin/sh
# build and run the PSS detector testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_pss_top -f tb.f -o tb_pss_sim

output=$(./obj_dir/tb_pss_sim)
printf '%s\n' "$output"

# a missing pass line makes grep, and the script, fail
printf '%s\n' "$output" | grep -q "TEST RESULT: PASS"
